// ==== src/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and address width
`define XLEN 32

// Register specifier width
`define REG_ADDR_W 5

// General purpose registers
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== src/mips_isa_pkg.sv ====
`default_nettype none
`include "mips_defs.svh"

package mips_isa_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // Two views of the same word
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== src/mips_pipe_pkg.sv ====
`default_nettype none
`include "mips_defs.svh"

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        alu_op_e          alu_op;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
        logic [`XLEN-1:0] store_data;
        reg_addr_t        rd;
        logic             we;
        logic             is_load;
        logic             is_store;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        // Also the memory address for loads and stores
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] store_data;
        reg_addr_t        rd;
        logic             we;
        logic             is_load;
        logic             is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0] wdata;
        reg_addr_t        rd;
        logic             we;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== src/mips_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

interface reg_read_if;
    import mips_isa_pkg::*;

    logic             re1;
    logic             re2;
    reg_addr_t        raddr1;
    reg_addr_t        raddr2;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;

    modport decoder (output re1, re2, raddr1, raddr2, input rdata1, rdata2);
    modport file    (input re1, re2, raddr1, raddr2, output rdata1, rdata2);
endinterface

interface fwd_if;
    import mips_isa_pkg::*;

    // Execute stage result
    logic             ex_we;
    reg_addr_t        ex_rd;
    logic [`XLEN-1:0] ex_result;
    logic             ex_is_load;
    // Memory stage result
    logic             mem_we;
    reg_addr_t        mem_rd;
    logic [`XLEN-1:0] mem_wdata;

    modport execute  (output ex_we, ex_rd, ex_result, ex_is_load);
    modport memory   (output mem_we, mem_rd, mem_wdata);
    modport consumer (input ex_we, ex_rd, ex_result, ex_is_load, mem_we, mem_rd, mem_wdata);
endinterface

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  logic [`XLEN-1:0]     rom_data_i,
    output logic [`XLEN-1:0]     rom_addr_o,
    output logic                 rom_ce_o,
    output mips_isa_pkg::instr_u instr_o
);

    logic [`XLEN-1:0] pc_q;

    // ROM enabled from the first edge after reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (rom_ce_o && !stall_i) begin
            pc_q <= pc_q + 'd4;
        end
    end

    // IF/ID register holds a nop while the ROM is still off
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_o <= '0;
        end else if (!stall_i) begin
            instr_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

    assign rom_addr_o = pc_q;

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  mips_isa_pkg::instr_u  instr_i,
    reg_read_if.decoder           rf,
    fwd_if.consumer               fwd,
    output logic                  stall_o,
    output mips_pipe_pkg::id_ex_t id_ex_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    id_ex_t           ctl;
    id_ex_t           id_ex_d;
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    logic             re1;
    logic             re2;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;

    // Execute result wins over memory result
    // Register 0 is never forwarded
    function automatic logic [`XLEN-1:0] pick_operand(
        input logic             re,
        input reg_addr_t        addr,
        input logic [`XLEN-1:0] rf_data
    );
        logic [`XLEN-1:0] val;
        val = rf_data;
        if (re && addr != '0) begin
            if (fwd.ex_we && fwd.ex_rd == addr) begin
                val = fwd.ex_result;
            end else if (fwd.mem_we && fwd.mem_rd == addr) begin
                val = fwd.mem_wdata;
            end
        end
        return val;
    endfunction

    always_comb begin
        ctl     = '0;
        imm     = '0;
        use_imm = 1'b0;
        re1     = 1'b0;
        re2     = 1'b0;
        case (instr_i.r.opcode)
            OP_SPECIAL: begin
                re1    = 1'b1;
                re2    = 1'b1;
                ctl.rd = instr_i.r.rd;
                ctl.we = 1'b1;
                case (instr_i.r.funct)
                    FN_ADDU: ctl.alu_op = ALU_ADD;
                    FN_SUBU: ctl.alu_op = ALU_SUB;
                    FN_AND:  ctl.alu_op = ALU_AND;
                    FN_OR:   ctl.alu_op = ALU_OR;
                    FN_XOR:  ctl.alu_op = ALU_XOR;
                    FN_SLT:  ctl.alu_op = ALU_SLT;
                    default: begin
                        re1    = 1'b0;
                        re2    = 1'b0;
                        ctl.we = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                imm          = {{(`XLEN-16){instr_i.i.imm[15]}}, instr_i.i.imm};
                use_imm      = 1'b1;
                re1          = 1'b1;
                re2          = instr_i.i.opcode == OP_SW;
                ctl.alu_op   = ALU_ADD;
                ctl.rd       = instr_i.i.rt;
                ctl.we       = instr_i.i.opcode != OP_SW;
                ctl.is_load  = instr_i.i.opcode == OP_LW;
                ctl.is_store = instr_i.i.opcode == OP_SW;
            end
            OP_ANDI: begin
                imm        = {{(`XLEN-16){1'b0}}, instr_i.i.imm};
                use_imm    = 1'b1;
                re1        = 1'b1;
                ctl.alu_op = ALU_AND;
                ctl.rd     = instr_i.i.rt;
                ctl.we     = 1'b1;
            end
            OP_ORI: begin
                imm        = {{(`XLEN-16){1'b0}}, instr_i.i.imm};
                use_imm    = 1'b1;
                re1        = 1'b1;
                ctl.alu_op = ALU_OR;
                ctl.rd     = instr_i.i.rt;
                ctl.we     = 1'b1;
            end
            OP_LUI: begin
                imm        = {instr_i.i.imm, {(`XLEN-16){1'b0}}};
                use_imm    = 1'b1;
                ctl.alu_op = ALU_PASS_B;
                ctl.rd     = instr_i.i.rt;
                ctl.we     = 1'b1;
            end
            default: ;
        endcase
    end

    assign rf.re1    = re1;
    assign rf.re2    = re2;
    assign rf.raddr1 = instr_i.r.rs;
    assign rf.raddr2 = instr_i.r.rt;

    always_comb begin
        src1               = pick_operand(re1, instr_i.r.rs, rf.rdata1);
        src2               = pick_operand(re2, instr_i.r.rt, rf.rdata2);
        id_ex_d            = ctl;
        id_ex_d.op_a       = src1;
        id_ex_d.op_b       = use_imm ? imm : src2;
        id_ex_d.store_data = src2;
    end

    // Load result not ready until the memory stage
    assign stall_o = fwd.ex_is_load && fwd.ex_we && fwd.ex_rd != '0 &&
                     ((re1 && fwd.ex_rd == instr_i.r.rs) ||
                      (re2 && fwd.ex_rd == instr_i.r.rt));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (stall_o) begin
            // Bubble
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    reg_read_if.file               rf,
    input  mips_pipe_pkg::mem_wb_t mem_wb_i
);
    import mips_isa_pkg::*;

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (mem_wb_i.we && mem_wb_i.rd != '0) begin
            regs[mem_wb_i.rd] <= mem_wb_i.wdata;
        end
    end

    // Same-cycle write is visible to the reader
    function automatic logic [`XLEN-1:0] read_port(input logic re, input reg_addr_t addr);
        logic [`XLEN-1:0] val;
        if (!re || addr == '0) begin
            val = '0;
        end else if (mem_wb_i.we && mem_wb_i.rd == addr) begin
            val = mem_wb_i.wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rf.rdata1 = read_port(rf.re1, rf.raddr1);
        rf.rdata2 = read_port(rf.re2, rf.raddr2);
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mips_pipe_pkg::id_ex_t  id_ex_i,
    fwd_if.execute                 fwd,
    output mips_pipe_pkg::ex_mem_t ex_mem_o
);
    import mips_pipe_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;

    assign op_a = id_ex_i.op_a;
    assign op_b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            // Signed compare
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    assign fwd.ex_we      = id_ex_i.we;
    assign fwd.ex_rd      = id_ex_i.rd;
    assign fwd.ex_result  = result;
    assign fwd.ex_is_load = id_ex_i.is_load;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= '{
                result:     result,
                store_data: id_ex_i.store_data,
                rd:         id_ex_i.rd,
                we:         id_ex_i.we,
                is_load:    id_ex_i.is_load,
                is_store:   id_ex_i.is_store
            };
        end
    end

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mips_pipe_pkg::ex_mem_t ex_mem_i,
    input  logic [`XLEN-1:0]       ram_data_i,
    output logic [`XLEN-1:0]       ram_addr_o,
    output logic [`XLEN-1:0]       ram_data_o,
    output logic                   ram_we_o,
    output logic [`XLEN/8-1:0]     ram_sel_o,
    output logic                   ram_ce_o,
    fwd_if.memory                  fwd,
    output mips_pipe_pkg::mem_wb_t mem_wb_o
);

    logic [`XLEN-1:0] wdata;

    // Word accesses only with all byte lanes on
    assign ram_ce_o   = ex_mem_i.is_load | ex_mem_i.is_store;
    assign ram_we_o   = ex_mem_i.is_store;
    assign ram_sel_o  = {(`XLEN/8){ram_ce_o}};
    assign ram_addr_o = ex_mem_i.result;
    assign ram_data_o = ex_mem_i.store_data;

    assign wdata = ex_mem_i.is_load ? ram_data_i : ex_mem_i.result;

    assign fwd.mem_we    = ex_mem_i.we;
    assign fwd.mem_rd    = ex_mem_i.rd;
    assign fwd.mem_wdata = wdata;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o <= '{
                wdata: wdata,
                rd:    ex_mem_i.rd,
                we:    ex_mem_i.we
            };
        end
    end

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_core (
    input  logic               clk,
    input  logic               arst_n_i,

    output logic [`XLEN-1:0]   rom_addr_o,
    output logic               rom_ce_o,
    input  logic [`XLEN-1:0]   rom_data_i,

    output logic [`XLEN-1:0]   ram_addr_o,
    output logic [`XLEN-1:0]   ram_data_o,
    output logic               ram_we_o,
    output logic [`XLEN/8-1:0] ram_sel_o,
    output logic               ram_ce_o,
    input  logic [`XLEN-1:0]   ram_data_i
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    instr_u  if_instr;
    logic    id_stall;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    reg_read_if rf_bus ();
    fwd_if      fwd_bus ();

    fetch_stage fetch0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (id_stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .instr_o    (if_instr)
    );

    decode_stage decode0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .instr_i    (if_instr),
        .rf         (rf_bus),
        .fwd        (fwd_bus),
        .stall_o    (id_stall),
        .id_ex_o    (id_ex)
    );

    regfile regfile0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rf         (rf_bus),
        .mem_wb_i   (mem_wb)
    );

    execute_stage execute0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .fwd        (fwd_bus),
        .ex_mem_o   (ex_mem)
    );

    memory_stage memory0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ex_mem_i   (ex_mem),
        .ram_data_i (ram_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_sel_o  (ram_sel_o),
        .ram_ce_o   (ram_ce_o),
        .fwd        (fwd_bus),
        .mem_wb_o   (mem_wb)
    );

endmodule

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_core_tb;

    typedef enum {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_LUI} op_kind_e;
    typedef enum {SEL_REG, SEL_IMM, SEL_NEG_IMM, SEL_REG_MIX} sel_e;

    localparam int MEM_WORDS = 256;
    localparam int MAX_ROWS  = 16;
    localparam int TIMEOUT   = 2000;
    localparam logic [15:0] LOAD_ADDR = 16'h0200;

    logic               clk = 1'b0;
    logic               arst_n_i;
    logic [`XLEN-1:0]   rom_addr_o;
    logic               rom_ce_o;
    logic [`XLEN-1:0]   rom_data_i;
    logic [`XLEN-1:0]   ram_addr_o;
    logic [`XLEN-1:0]   ram_data_o;
    logic               ram_we_o;
    logic [`XLEN/8-1:0] ram_sel_o;
    logic               ram_ce_o;
    logic [`XLEN-1:0]   ram_data_i;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];

    // Stores seen on the RAM port and the ones the program should make
    logic [31:0] obs_addr [$];
    logic [31:0] obs_data [$];
    logic [3:0]  obs_sel [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    op_kind_e    row_op [MAX_ROWS];
    sel_e        row_sel [MAX_ROWS];
    logic [15:0] row_addr [MAX_ROWS];
    int          n_rows;

    logic [31:0] lfsr_state;
    int          pc_idx;
    logic [31:0] lw_pc;
    logic [31:0] prev_pc;
    logic        seen_ce;
    int          repeat_count;
    logic [31:0] repeat_addr;

    mips_core dut (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .rom_data_i (rom_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_sel_o  (ram_sel_o),
        .ram_ce_o   (ram_ce_o),
        .ram_data_i (ram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign rom_data_i = rom[rom_addr_o[9:2]];
    assign ram_data_i = ram[ram_addr_o[9:2]];

    always @(posedge clk) begin
        if (ram_ce_o && ram_we_o) begin
            ram[ram_addr_o[9:2]] <= ram_data_o;
            obs_addr.push_back(ram_addr_o);
            obs_data.push_back(ram_data_o);
            obs_sel.push_back(ram_sel_o);
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stop_run("first mismatch reached, run stopped");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] ram_fill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Operation into r3 from r1 and r2 or the immediate
    function automatic logic [31:0] encode_op(input op_kind_e op, input sel_e sel,
                                              input logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        if (sel == SEL_REG || sel == SEL_REG_MIX) begin
            case (op)
                K_ADD:   w = r_word(6'h21, 5'd1, 5'd2, 5'd3);
                K_SUB:   w = r_word(6'h23, 5'd1, 5'd2, 5'd3);
                K_AND:   w = r_word(6'h24, 5'd1, 5'd2, 5'd3);
                K_OR:    w = r_word(6'h25, 5'd1, 5'd2, 5'd3);
                K_XOR:   w = r_word(6'h26, 5'd1, 5'd2, 5'd3);
                K_SLT:   w = r_word(6'h2a, 5'd1, 5'd2, 5'd3);
                default: w = '0;
            endcase
        end else begin
            case (op)
                K_ADD:   w = i_word(6'h09, 5'd1, 5'd3, imm);
                K_AND:   w = i_word(6'h0c, 5'd1, 5'd3, imm);
                K_OR:    w = i_word(6'h0d, 5'd1, 5'd3, imm);
                K_LUI:   w = i_word(6'h0f, 5'd0, 5'd3, imm);
                default: w = '0;
            endcase
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_result(input op_kind_e op, input sel_e sel,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b,
                                                    input logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        case (op)
            K_ADD:   res = a + ((sel == SEL_REG) ? b : sx);
            K_SUB:   res = a - b;
            K_AND:   res = a & ((sel == SEL_REG) ? b : zx);
            K_OR:    res = a | ((sel == SEL_REG) ? b : zx);
            K_XOR:   res = a ^ b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_LUI:   res = {imm, 16'h0000};
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[pc_idx] = w;
        pc_idx++;
    endtask

    task automatic load_const(input logic [4:0] r, input logic [31:0] value);
        emit(i_word(6'h0f, 5'd0, r, value[31:16]));
        emit(i_word(6'h0d, r, r, value[15:0]));
    endtask

    task automatic add_row(input op_kind_e op, input sel_e sel, input logic [15:0] addr);
        row_op[n_rows]   = op;
        row_sel[n_rows]  = sel;
        row_addr[n_rows] = addr;
        n_rows++;
    endtask

    task automatic build_row(input int r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [15:0] imm;
        take_bits(32, a);
        take_bits(32, b);
        take_bits(16, rnd);
        imm = rnd[15:0];
        if (row_sel[r] == SEL_NEG_IMM) begin
            imm[15] = 1'b1;
        end
        // Opposite signs tell a signed compare from an unsigned one
        if (row_sel[r] == SEL_REG_MIX) begin
            b[31] = ~a[31];
        end
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(encode_op(row_op[r], row_sel[r], imm));
        emit(i_word(6'h2b, 5'd0, 5'd3, row_addr[r]));
        exp_addr.push_back({16'h0000, row_addr[r]});
        exp_data.push_back(expected_result(row_op[r], row_sel[r], a, b, imm));
    endtask

    // LW then a dependent ADDU costs one bubble
    task automatic build_load_use();
        logic [31:0] a;
        take_bits(32, a);
        load_const(5'd1, a);
        lw_pc = pc_idx * 4;
        emit(i_word(6'h23, 5'd0, 5'd4, LOAD_ADDR));
        emit(r_word(6'h21, 5'd4, 5'd1, 5'd5));
        emit(i_word(6'h2b, 5'd0, 5'd5, 16'h0138));
        exp_addr.push_back(32'h0000_0138);
        exp_data.push_back(ram_fill({16'h0000, LOAD_ADDR}) + a);
    endtask

    task automatic build_r0_check();
        emit(i_word(6'h0d, 5'd0, 5'd0, 16'h5a5a));
        emit(i_word(6'h2b, 5'd0, 5'd0, 16'h013c));
        exp_addr.push_back(32'h0000_013c);
        exp_data.push_back(32'h0000_0000);
    endtask

    // Fetch side sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n_i) begin
            compare_value(rom_addr_o, `RESET_PC, "rom_addr_o in reset");
            compare_value({31'd0, ram_ce_o}, 32'd0, "ram_ce_o in reset");
            compare_value({31'd0, ram_we_o}, 32'd0, "ram_we_o in reset");
        end else if (seen_ce) begin
            compare_value({31'd0, rom_ce_o}, 32'd1, "rom_ce_o after reset");
            if (rom_addr_o == prev_pc) begin
                repeat_count++;
                repeat_addr = rom_addr_o;
            end else begin
                compare_value(rom_addr_o, prev_pc + 32'd4, "rom_addr_o step");
            end
            prev_pc = rom_addr_o;
        end else if (rom_ce_o) begin
            seen_ce = 1'b1;
            compare_value(rom_addr_o, `RESET_PC, "first fetch address");
            prev_pc = rom_addr_o;
        end
    end

    initial begin
        int cycles;
        arst_n_i     = 1'b0;
        lfsr_state   = 32'd7245;
        pc_idx       = 0;
        n_rows       = 0;
        seen_ce      = 1'b0;
        repeat_count = 0;
        repeat_addr  = '0;
        prev_pc      = '0;
        lw_pc        = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = '0;
            ram[i] = ram_fill(i * 4);
        end

        add_row(K_ADD, SEL_REG,     16'h0100);
        add_row(K_SUB, SEL_REG,     16'h0104);
        add_row(K_AND, SEL_REG,     16'h0108);
        add_row(K_OR,  SEL_REG,     16'h010c);
        add_row(K_XOR, SEL_REG,     16'h0110);
        add_row(K_SLT, SEL_REG,     16'h0114);
        add_row(K_SLT, SEL_REG_MIX, 16'h0118);
        add_row(K_ADD, SEL_IMM,     16'h011c);
        add_row(K_ADD, SEL_NEG_IMM, 16'h0120);
        add_row(K_AND, SEL_NEG_IMM, 16'h0124);
        add_row(K_OR,  SEL_IMM,     16'h0128);
        add_row(K_LUI, SEL_IMM,     16'h012c);
        add_row(K_SUB, SEL_REG,     16'h0130);
        add_row(K_ADD, SEL_NEG_IMM, 16'h0134);
        for (int r = 0; r < n_rows; r++) begin
            build_row(r);
        end
        build_load_use();
        build_r0_check();

        repeat (8) @(negedge clk);
        arst_n_i <= 1'b1;

        cycles = 0;
        while (obs_addr.size() < exp_addr.size() && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (obs_addr.size() < exp_addr.size()) begin
            stop_run("Timed out waiting for the program's stores to reach the RAM");
        end

        // No further store may show up while the pipeline drains
        cycles = 0;
        while (cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        compare_value(obs_addr.size(), exp_addr.size(), "number of stores");
        for (int i = 0; i < exp_addr.size(); i++) begin
            compare_value(obs_addr[i], exp_addr[i], $sformatf("store %0d address", i));
            compare_value(obs_data[i], exp_data[i], $sformatf("store %0d data", i));
            compare_value({28'd0, obs_sel[i]}, 32'h0000_000f, $sformatf("store %0d sel", i));
        end
        compare_value(repeat_count, 32'd1, "rom_addr_o repeat count");
        compare_value(repeat_addr, lw_pc + 32'd8, "rom_addr_o held during load-use");

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+src
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/mips_ifs.sv
src/fetch_stage.sv
src/decode_stage.sv
src/regfile.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
bench/mips_core_tb.sv
